/* files.f */
hdl/ac97_pkg.sv
hdl/ac97_sample_tick.sv
hdl/ac97_sample_fifo.sv
hdl/ac97_codec_regs.sv
hdl/ac97_bus_regs.sv
hdl/ac97ctrl_top.sv
verif/ac97ctrl_chk.sv
verif/ac97ctrl_tb.sv

/* Makefile */
# Verilator simulation of the AC97 controller

VERILATOR ?= verilator
TOP       ?= ac97ctrl_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VL_FLAGS  ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VL_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)

/* verif/ac97ctrl_tb.sv */
`timescale 1ns/1ns

module ac97ctrl_tb import ac97_pkg::*; ();

  localparam int ACK_LIMIT  = 16;    // bus cycles
  localparam int TICK_LIMIT = 3000;  // longer than one long run
  localparam int POLL_LIMIT = 20;    // status reads

  logic        clk_adc_125mhz;
  logic        adc_rstn;
  sys_req_t    sys_req;
  sys_rsp_t    sys_rsp;
  stereo_t     line_in;
  stereo_t     line_out;
  logic        tick;
  logic [31:0] rnd = 32'h7330_f966;  // lcg state

  ac97ctrl_top dut0 (
    .clk_adc_125mhz  (clk_adc_125mhz),
    .adc_rstn_i      (adc_rstn),
    .sys_req_i       (sys_req),
    .ac97_line_in_i  (line_in),
    .sys_rsp_o       (sys_rsp),
    .ac97_line_out_o (line_out),
    .ac97_tick_o     (tick)
  );

  initial begin
    clk_adc_125mhz = 1'b0;
    forever #4 clk_adc_125mhz = ~clk_adc_125mhz;  // 125 MHz
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else abort_run($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  task automatic expect_bit(input string name, input logic [31:0] word, input int pos,
                            input logic exp);
    expect_eq(name, 32'(word[pos]), 32'(exp));
  endtask

  // ------------------------------
  // bus and tick helpers
  task automatic bus_access(input logic wr, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int n;
    @(posedge clk_adc_125mhz);
    sys_req <= '{addr: addr, wdata: wdata, wen: wr, ren: !wr};  // one cycle strobe
    @(posedge clk_adc_125mhz);
    sys_req <= '0;
    n = 0;
    do begin
      @(negedge clk_adc_125mhz);  // ack stable mid cycle
      n++;
      if (n > ACK_LIMIT) abort_run("no ack on the system bus");
    end while (!sys_rsp.ack);
    rdata = sys_rsp.rdata;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] ignored;
    bus_access(1'b1, addr, data, ignored);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    bus_access(1'b0, addr, 32'h0, data);
  endtask

  task automatic wait_tick();
    int n;
    n = 0;
    do begin
      @(negedge clk_adc_125mhz);
      n++;
      if (n > TICK_LIMIT) abort_run("no sample tick within one run");
    end while (!tick);
  endtask

  task automatic wait_access_done();
    logic [31:0] st;
    int n;
    n = 0;
    do begin
      bus_read(32'(REG_STAT), st);  // first read already sees done cleared
      n++;
      if (n > POLL_LIMIT) abort_run("codec register access never finished");
    end while (!st[STAT_ACCESS_DONE]);
  endtask

  // checker in the dut flags protocol or tick faults
  always @(negedge clk_adc_125mhz) begin
    if (dut0.chk0.fail_cnt != 0) abort_run("bus protocol or tick spacing assertion failed");
  end

  // ------------------------------
  // stimulus
  initial begin
    logic [31:0] rd;
    logic [15:0] cval [2];
    stereo_t     pair [3];
    stereo_t     held;
    adc_rstn = 1'b0;
    sys_req  = '0;
    line_in  = '0;
    repeat (2) @(posedge clk_adc_125mhz);
    adc_rstn <= 1'b1;

    bus_read(32'(REG_STAT), rd);
    expect_eq("stat", rd, 32'h0000_000A);  // play half, rec empty

    for (int i = 0; i < 2; i++) begin  // store two codec words
      rnd     = lcg_step(rnd);
      cval[i] = rnd[31:16];
      bus_write(32'(REG_CODEC_WDATA), {16'h0, cval[i]});
      bus_write(32'(REG_CODEC_ADDR), (i == 0) ? 32'h02 : 32'h7E);
      wait_access_done();
    end
    for (int i = 0; i < 2; i++) begin  // recall, bit7 selects read
      bus_write(32'(REG_CODEC_ADDR), ((i == 0) ? 32'h02 : 32'h7E) | 32'h80);
      wait_access_done();
      bus_read(32'(REG_CODEC_RDATA), rd);
      expect_eq("codec_rdata", rd, {16'h0, cval[i]});
    end

    // play path, all writes land well inside one run
    wait_tick();
    bus_write(32'(REG_FIFO_RESET), 32'h1);
    for (int i = 0; i < 3; i++) begin
      rnd     = lcg_step(rnd);
      pair[i] = rnd;
      bus_write(32'(REG_FIFO_PLAY), {16'h0, pair[i].left});
      bus_write(32'(REG_FIFO_PLAY), {16'h0, pair[i].right});  // pushes the pair
    end
    bus_read(32'(REG_STAT), rd);
    expect_bit("stat.play_underrun", rd, STAT_PLAY_UNDERRUN, 1'b0);
    for (int i = 0; i < 3; i++) begin
      expect_eq("ac97_line_out", line_out, pair[i]);
      wait_tick();
      @(negedge clk_adc_125mhz);  // pop lands on the edge after tick
    end
    expect_eq("ac97_line_out", line_out, 32'h0);
    wait_tick();
    bus_read(32'(REG_STAT), rd);
    expect_bit("stat.play_underrun", rd, STAT_PLAY_UNDERRUN, 1'b1);
    bus_write(32'(REG_FIFO_RESET), 32'h1);
    bus_read(32'(REG_STAT), rd);
    expect_bit("stat.play_underrun", rd, STAT_PLAY_UNDERRUN, 1'b0);

    // record path
    wait_tick();
    rnd  = lcg_step(rnd);
    held = rnd;
    @(posedge clk_adc_125mhz);
    line_in <= held;
    bus_write(32'(REG_FIFO_RESET), 32'h2);
    wait_tick();
    bus_read(32'(REG_FIFO_REC), rd);
    expect_eq("rec_left", rd, {16'h0, held.left});
    bus_read(32'(REG_FIFO_REC), rd);
    expect_eq("rec_right", rd, {16'h0, held.right});
    bus_read(32'(REG_STAT), rd);
    expect_bit("stat.rec_empty", rd, STAT_REC_EMPTY, 1'b1);

    // record overrun, 16 fill and one more drops
    wait_tick();
    bus_write(32'(REG_FIFO_RESET), 32'h2);
    repeat (17) wait_tick();
    bus_read(32'(REG_STAT), rd);
    expect_bit("stat.rec_full", rd, STAT_REC_FULL, 1'b1);
    expect_bit("stat.rec_overrun", rd, STAT_REC_OVERRUN, 1'b1);
    bus_write(32'(REG_FIFO_RESET), 32'h2);
    bus_read(32'(REG_STAT), rd);
    expect_bit("stat.rec_full", rd, STAT_REC_FULL, 1'b0);
    expect_bit("stat.rec_overrun", rd, STAT_REC_OVERRUN, 1'b0);
    expect_bit("stat.rec_empty", rd, STAT_REC_EMPTY, 1'b1);

    bus_read(32'h0000_0040, rd);  // unmapped offset
    expect_eq("rdata_0x40", rd, 32'h0);

    repeat (4) @(posedge clk_adc_125mhz);
    if (dut0.chk0.fail_cnt == 0) begin
      $display("No errors");
      $finish;
    end else begin
      abort_run("bus protocol or tick spacing assertion failed");
    end
  end

endmodule

/* verif/ac97ctrl_chk.sv */
`timescale 1ns/1ns

module ac97ctrl_chk import ac97_pkg::*; (
  input logic     clk_adc_125mhz,  // 125 MHz adc clock
  input logic     adc_rstn_i,      // sync, active low
  input sys_req_t req_i,           // bus request into the dut
  input sys_rsp_t rsp_i,           // bus response from the dut
  input logic     tick_i           // 48 kHz sample tick
);

  int unsigned fail_cnt = 0;  // failed assertions so far
  logic [11:0] gap_q;         // cycles since last tick, saturates

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      gap_q <= '1;  // no tick seen yet
    end else if (tick_i) begin
      gap_q <= 12'd1;
    end else if (gap_q != '1) begin
      gap_q <= gap_q + 12'd1;
    end
  end

  // ------------------------------
  // bus handshake
  ack_follows_req : assert property (@(posedge clk_adc_125mhz) disable iff (!adc_rstn_i)
    (req_i.wen || req_i.ren) |=> rsp_i.ack)
    else begin
      fail_cnt++;
      $error("request without ack one cycle later");
    end

  ack_only_after_req : assert property (@(posedge clk_adc_125mhz) disable iff (!adc_rstn_i)
    rsp_i.ack |-> $past(req_i.wen || req_i.ren))
    else begin
      fail_cnt++;
      $error("ack without a request one cycle before");
    end

  err_never_set : assert property (@(posedge clk_adc_125mhz) disable iff (!adc_rstn_i)
    !rsp_i.err)
    else begin
      fail_cnt++;
      $error("bus err raised");
    end

  // ------------------------------
  // shortest run is TICK_CTR_MAX cycles
  tick_spacing : assert property (@(posedge clk_adc_125mhz) disable iff (!adc_rstn_i)
    tick_i |-> (gap_q >= 12'(TICK_CTR_MAX)))
    else begin
      fail_cnt++;
      $error("sample tick came too early");
    end

endmodule

bind ac97ctrl_top ac97ctrl_chk chk0 (
  .clk_adc_125mhz (clk_adc_125mhz),
  .adc_rstn_i     (adc_rstn_i),
  .req_i          (sys_req_i),
  .rsp_i          (sys_rsp_o),
  .tick_i         (ac97_tick_o)
);

/* hdl/ac97ctrl_top.sv */
`timescale 1ns/1ns

module ac97ctrl_top import ac97_pkg::*; (
  input  logic     clk_adc_125mhz,   // 125 MHz adc clock
  input  logic     adc_rstn_i,       // sync, active low
  input  sys_req_t sys_req_i,
  input  stereo_t  ac97_line_in_i,   // sampled each tick
  output sys_rsp_t sys_rsp_o,
  output stereo_t  ac97_line_out_o,  // play fifo head
  output logic     ac97_tick_o
);

  logic                    tick;
  logic                    play_push;
  logic                    play_pop;
  logic                    play_clear;
  stereo_t                 play_data;
  logic [FIFO_CNT_W-1:0]   play_count;
  logic                    rec_push;
  logic                    rec_pop;
  logic                    rec_clear;
  stereo_t                 rec_head;
  logic [FIFO_CNT_W-1:0]   rec_count;
  logic                    codec_start;
  codec_op_e               codec_op;
  logic [CODEC_ADDR_W-1:0] codec_addr;
  sample_t                 codec_wdata;
  sample_t                 codec_rdata;
  logic                    access_done;

  ac97_sample_tick u_tick (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn_i),
    .tick_o         (tick)
  );

  // ------------------------------
  // play and record fifos
  ac97_sample_fifo u_play_fifo (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn_i),
    .clear_i        (play_clear),
    .push_i         (play_push),
    .data_i         (play_data),
    .pop_i          (play_pop),
    .head_o         (ac97_line_out_o),
    .count_o        (play_count)
  );

  ac97_sample_fifo u_rec_fifo (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn_i),
    .clear_i        (rec_clear),
    .push_i         (rec_push),
    .data_i         (ac97_line_in_i),
    .pop_i          (rec_pop),
    .head_o         (rec_head),
    .count_o        (rec_count)
  );

  ac97_codec_regs u_codec_regs (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn_i),
    .start_i        (codec_start),
    .op_i           (codec_op),
    .addr_i         (codec_addr),
    .wdata_i        (codec_wdata),
    .rdata_o        (codec_rdata),
    .access_done_o  (access_done)
  );

  // ------------------------------
  // register block on the system bus
  ac97_bus_regs u_bus_regs (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn_i),
    .req_i          (sys_req_i),
    .tick_i         (tick),
    .play_count_i   (play_count),
    .rec_count_i    (rec_count),
    .rec_head_i     (rec_head),
    .codec_rdata_i  (codec_rdata),
    .access_done_i  (access_done),
    .rsp_o          (sys_rsp_o),
    .play_push_o    (play_push),
    .play_data_o    (play_data),
    .play_pop_o     (play_pop),
    .play_clear_o   (play_clear),
    .rec_push_o     (rec_push),
    .rec_pop_o      (rec_pop),
    .rec_clear_o    (rec_clear),
    .codec_start_o  (codec_start),
    .codec_op_o     (codec_op),
    .codec_addr_o   (codec_addr),
    .codec_wdata_o  (codec_wdata)
  );

  assign ac97_tick_o = tick;

endmodule

/* hdl/ac97_bus_regs.sv */
`timescale 1ns/1ns

module ac97_bus_regs import ac97_pkg::*; (
  input  logic                    clk_adc_125mhz,  // 125 MHz adc clock
  input  logic                    adc_rstn_i,      // sync, active low
  input  sys_req_t                req_i,
  input  logic                    tick_i,          // 48 kHz sample tick
  input  logic [FIFO_CNT_W-1:0]   play_count_i,
  input  logic [FIFO_CNT_W-1:0]   rec_count_i,
  input  stereo_t                 rec_head_i,
  input  sample_t                 codec_rdata_i,
  input  logic                    access_done_i,
  output sys_rsp_t                rsp_o,
  output logic                    play_push_o,
  output stereo_t                 play_data_o,
  output logic                    play_pop_o,
  output logic                    play_clear_o,
  output logic                    rec_push_o,
  output logic                    rec_pop_o,
  output logic                    rec_clear_o,
  output logic                    codec_start_o,
  output codec_op_e               codec_op_o,
  output logic [CODEC_ADDR_W-1:0] codec_addr_o,
  output sample_t                 codec_wdata_o
);

  reg_addr_e               reg_addr;       // decoded offset
  logic                    wr_play;
  logic                    rd_rec;
  logic [7:0]              stat;
  sample_t                 play_left_q;    // pair holding registers
  sample_t                 play_right_q;
  logic                    play_is_right_q;  // play run flag
  logic                    rec_is_right_q;   // record run flag
  logic                    right_wr_q;       // right sample just written
  logic                    play_push_q;
  logic                    rec_pop_q;
  logic                    play_clear_q;
  logic                    rec_clear_q;
  logic                    underrun_q;
  logic                    overrun_q;
  logic                    start_q;
  codec_op_e               codec_op_q;
  logic [CODEC_ADDR_W-1:0] codec_addr_q;
  sample_t                 codec_wdata_q;
  logic [BUS_W-1:0]        rdata_q;
  logic                    ack_q;

  assign reg_addr = reg_addr_e'(req_i.addr[19:0]);  // upper bits not decoded
  assign wr_play  = req_i.wen && (reg_addr == REG_FIFO_PLAY);
  assign rd_rec   = req_i.ren && (reg_addr == REG_FIFO_REC);

  // ------------------------------
  // write side and control pulses
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      play_is_right_q <= 1'b0;
      rec_is_right_q  <= 1'b0;
      right_wr_q      <= 1'b0;
      play_push_q     <= 1'b0;
      rec_pop_q       <= 1'b0;
      play_clear_q    <= 1'b0;
      rec_clear_q     <= 1'b0;
      start_q         <= 1'b0;
      codec_op_q      <= CODEC_WRITE;
    end else begin
      right_wr_q   <= wr_play && play_is_right_q;
      play_push_q  <= right_wr_q;                  // pair complete, push next cycle
      rec_pop_q    <= rd_rec && rec_is_right_q;    // right read pops
      play_clear_q <= req_i.wen && (reg_addr == REG_FIFO_RESET) && req_i.wdata[0];
      rec_clear_q  <= req_i.wen && (reg_addr == REG_FIFO_RESET) && req_i.wdata[1];
      start_q      <= req_i.wen && (reg_addr == REG_CODEC_ADDR);
      if (play_clear_q) begin
        play_is_right_q <= 1'b0;                   // back to left
      end else if (wr_play) begin
        play_is_right_q <= !play_is_right_q;
      end
      if (rec_clear_q) begin
        rec_is_right_q <= 1'b0;
      end else if (rd_rec) begin
        rec_is_right_q <= !rec_is_right_q;
      end
      if (req_i.wen && (reg_addr == REG_CODEC_ADDR)) begin
        codec_op_q <= codec_op_e'(req_i.wdata[7]);  // bit7 set reads
      end
    end
  end

  // payload registers
  always_ff @(posedge clk_adc_125mhz) begin
    if (wr_play && !play_is_right_q) begin
      play_left_q <= req_i.wdata[SAMPLE_W-1:0];
    end
    if (wr_play && play_is_right_q) begin
      play_right_q <= req_i.wdata[SAMPLE_W-1:0];
    end
    if (req_i.wen && (reg_addr == REG_CODEC_ADDR)) begin
      codec_addr_q <= req_i.wdata[CODEC_ADDR_W:1];  // even codec register offset
    end
    if (req_i.wen && (reg_addr == REG_CODEC_WDATA)) begin
      codec_wdata_q <= req_i.wdata[SAMPLE_W-1:0];
    end
  end

  // ------------------------------
  // sticky fifo flags, reset bits clear them
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      underrun_q <= 1'b0;
      overrun_q  <= 1'b0;
    end else begin
      if (play_clear_q) begin
        underrun_q <= 1'b0;
      end else if (tick_i && (play_count_i == '0)) begin
        underrun_q <= 1'b1;            // nothing to play at tick
      end
      if (rec_clear_q) begin
        overrun_q <= 1'b0;
      end else if (tick_i && (rec_count_i == FIFO_CNT_W'(FIFO_DEPTH))) begin
        overrun_q <= 1'b1;             // sample dropped by full fifo
      end
    end
  end

  always_comb begin
    stat                     = '0;
    stat[STAT_PLAY_FULL]     = (play_count_i == FIFO_CNT_W'(FIFO_DEPTH));
    stat[STAT_PLAY_HALF]     = (play_count_i <= FIFO_CNT_W'(FIFO_DEPTH / 2));
    stat[STAT_REC_FULL]      = (rec_count_i == FIFO_CNT_W'(FIFO_DEPTH));
    stat[STAT_REC_EMPTY]     = (rec_count_i == '0);
    stat[STAT_ACCESS_DONE]   = access_done_i;
    stat[STAT_CODEC_READY]   = 1'b0;
    stat[STAT_PLAY_UNDERRUN] = underrun_q;
    stat[STAT_REC_OVERRUN]   = overrun_q;
  end

  // ------------------------------
  // ack and read mux
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      ack_q   <= 1'b0;
      rdata_q <= '0;
    end else begin
      ack_q <= req_i.wen || req_i.ren;  // every request, one cycle later
      if (req_i.ren) begin
        case (reg_addr)
          REG_FIFO_REC:    rdata_q <= BUS_W'(rec_is_right_q ? rec_head_i.right
                                                            : rec_head_i.left);
          REG_STAT:        rdata_q <= BUS_W'(stat);
          REG_CODEC_RDATA: rdata_q <= BUS_W'(codec_rdata_i);
          default:         rdata_q <= '0;  // write-only or unmapped
        endcase
      end
    end
  end

  assign rsp_o         = '{rdata: rdata_q, ack: ack_q, err: 1'b0};
  assign play_push_o   = play_push_q;
  assign play_data_o   = '{right: play_right_q, left: play_left_q};
  assign play_pop_o    = tick_i;     // one pair out per tick
  assign play_clear_o  = play_clear_q;
  assign rec_push_o    = tick_i;     // line input in per tick
  assign rec_pop_o     = rec_pop_q;
  assign rec_clear_o   = rec_clear_q;
  assign codec_start_o = start_q;
  assign codec_op_o    = codec_op_q;
  assign codec_addr_o  = codec_addr_q;
  assign codec_wdata_o = codec_wdata_q;

endmodule

/* hdl/ac97_codec_regs.sv */
`timescale 1ns/1ns

module ac97_codec_regs import ac97_pkg::*; (
  input  logic                    clk_adc_125mhz,  // 125 MHz adc clock
  input  logic                    adc_rstn_i,      // sync, active low
  input  logic                    start_i,         // one cycle, from addr write
  input  codec_op_e               op_i,            // store or recall
  input  logic [CODEC_ADDR_W-1:0] addr_i,          // codec word address
  input  sample_t                 wdata_i,
  output sample_t                 rdata_o,         // last recalled word
  output logic                    access_done_o
);

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    DONE
  } state_e;

  state_e  state_q;
  sample_t mem_q [2**CODEC_ADDR_W];  // codec register shadow
  sample_t rdata_q;
  logic    done_q;

  // ------------------------------
  // access sequencing
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
      rdata_q <= '0;
    end else if (start_i) begin
      state_q <= ACCESS;  // restart from any state
      done_q  <= 1'b0;    // cleared by every start
    end else begin
      case (state_q)
        ACCESS: begin
          if (op_i == CODEC_READ) begin
            rdata_q <= mem_q[addr_i];  // recall into read register
          end
          done_q  <= 1'b1;             // two cycles after start
          state_q <= DONE;
        end
        DONE:    state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // store happens in the same cycle the recall would
  always_ff @(posedge clk_adc_125mhz) begin
    if (state_q == ACCESS && !start_i && op_i == CODEC_WRITE) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  assign rdata_o       = rdata_q;
  assign access_done_o = done_q;

endmodule

/* hdl/ac97_sample_fifo.sv */
`timescale 1ns/1ns

module ac97_sample_fifo import ac97_pkg::*; (
  input  logic                  clk_adc_125mhz,  // 125 MHz adc clock
  input  logic                  adc_rstn_i,      // sync, active low
  input  logic                  clear_i,         // empties fifo, beats push/pop
  input  logic                  push_i,
  input  stereo_t               data_i,
  input  logic                  pop_i,
  output stereo_t               head_o,          // show-ahead, 0 when empty
  output logic [FIFO_CNT_W-1:0] count_o
);

  stereo_t               mem_q [FIFO_DEPTH];  // circular buffer
  logic [FIFO_CNT_W-2:0] wr_ptr_q;            // wraps at depth
  logic [FIFO_CNT_W-2:0] rd_ptr_q;
  logic [FIFO_CNT_W-1:0] count_q;
  logic                  full;
  logic                  empty;
  logic                  do_push;
  logic                  do_pop;

  assign full    = (count_q == FIFO_CNT_W'(FIFO_DEPTH));
  assign empty   = (count_q == '0);
  assign do_push = push_i && !full;   // push into full is dropped
  assign do_pop  = pop_i && !empty;   // pop of empty is ignored

  // ------------------------------
  // pointers and occupancy
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i || clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // none or both
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_adc_125mhz) begin
    if (do_push && !clear_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign head_o  = empty ? '0 : mem_q[rd_ptr_q];
  assign count_o = count_q;

endmodule

/* hdl/ac97_sample_tick.sv */
`timescale 1ns/1ns

module ac97_sample_tick import ac97_pkg::*; (
  input  logic clk_adc_125mhz,  // 125 MHz adc clock
  input  logic adc_rstn_i,      // sync, active low
  output logic tick_o           // one cycle at 48 kHz
);

  logic [11:0] run_ctr_q;  // position in current run
  logic [2:0]  frc_ctr_q;  // short runs done since last long run
  logic        tick_q;

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      run_ctr_q <= '0;
      frc_ctr_q <= '0;
      tick_q    <= 1'b0;
    end else if (run_ctr_q == 12'(TICK_CTR_MAX)) begin
      tick_q <= 1'b1;
      if (frc_ctr_q == 3'(TICK_FRC_MAX)) begin
        frc_ctr_q <= '0;
        run_ctr_q <= 12'd0;  // restart at 0, one cycle longer
      end else begin
        frc_ctr_q <= frc_ctr_q + 3'd1;
        run_ctr_q <= 12'd1;  // short run
      end
    end else begin
      tick_q    <= 1'b0;
      run_ctr_q <= run_ctr_q + 12'd1;
    end
  end

  assign tick_o = tick_q;

endmodule

/* hdl/ac97_pkg.sv */
package ac97_pkg;

  // ------------------------------
  // sizes
  localparam int SAMPLE_W     = 16;    // one audio sample
  localparam int FIFO_DEPTH   = 16;    // stereo words per fifo
  localparam int FIFO_CNT_W   = 5;     // holds 0..16
  localparam int CODEC_ADDR_W = 6;     // 64 codec words
  localparam int BUS_W        = 32;    // system bus data width

  // 125 MHz / 48 kHz = 2604.17, five short runs then one long run
  localparam int TICK_CTR_MAX = 2604;  // end of a short run
  localparam int TICK_FRC_MAX = 5;     // short runs before a long one

  // ------------------------------
  // status register bit positions
  localparam int STAT_PLAY_FULL     = 0;
  localparam int STAT_PLAY_HALF     = 1;  // play count <= 8
  localparam int STAT_REC_FULL      = 2;
  localparam int STAT_REC_EMPTY     = 3;
  localparam int STAT_ACCESS_DONE   = 4;  // codec register access finished
  localparam int STAT_CODEC_READY   = 5;  // no codec behind us, reads 0
  localparam int STAT_PLAY_UNDERRUN = 6;
  localparam int STAT_REC_OVERRUN   = 7;

  typedef logic [SAMPLE_W-1:0] sample_t;

  typedef struct packed {
    sample_t right;  // upper half
    sample_t left;   // lower half
  } stereo_t;

  // register offsets, decoded on addr[19:0]
  typedef enum logic [19:0] {
    REG_FIFO_PLAY   = 20'h00000,  // wo, left then right
    REG_FIFO_REC    = 20'h00004,  // ro, left then right
    REG_STAT        = 20'h00008,  // ro
    REG_FIFO_RESET  = 20'h0000C,  // wo, bit0 play, bit1 rec
    REG_CODEC_ADDR  = 20'h00010,  // wo, bit7 selects read
    REG_CODEC_RDATA = 20'h00014,  // ro
    REG_CODEC_WDATA = 20'h00018   // wo
  } reg_addr_e;

  typedef enum logic {
    CODEC_WRITE = 1'b0,
    CODEC_READ  = 1'b1
  } codec_op_e;

  typedef struct packed {
    logic [BUS_W-1:0] addr;
    logic [BUS_W-1:0] wdata;
    logic             wen;    // one cycle strobe
    logic             ren;    // one cycle strobe
  } sys_req_t;

  typedef struct packed {
    logic [BUS_W-1:0] rdata;  // valid with ack
    logic             ack;
    logic             err;
  } sys_rsp_t;

endpackage
